// File: hw/fetch_pkg.sv
package fetch_pkg;

  // Fetch geometry.
  localparam int FETCH_WIDTH  = 2;
  localparam int LANE_BITS    = $clog2(FETCH_WIDTH);
  localparam int BUNDLE_BYTES = FETCH_WIDTH * 4;

  // Predictor sizing.
  localparam int GHR_BITS     = 4;
  localparam int PHT_ENTRIES  = 16;
  localparam int PHT_IDX_BITS = $clog2(PHT_ENTRIES);
  localparam int BTB_ENTRIES  = 8;
  localparam int BTB_IDX_BITS = $clog2(BTB_ENTRIES);
  localparam int BTB_TAG_BITS = 30 - BTB_IDX_BITS;

  // Instruction buffer.
  localparam int IB_DEPTH    = 4;
  localparam int IB_PTR_BITS = $clog2(IB_DEPTH);
  localparam int IB_CNT_BITS = $clog2(IB_DEPTH + 1);

  // Cache model, one line per bundle.
  localparam int MISS_CYCLES   = 4;
  localparam int MISS_CNT_BITS = $clog2(MISS_CYCLES);
  localparam int IMEM_WORDS    = 64;
  localparam int IMEM_IDX_BITS = $clog2(IMEM_WORDS);
  localparam int IMEM_LINES    = IMEM_WORDS / FETCH_WIDTH;
  localparam int LINE_IDX_BITS = $clog2(IMEM_LINES);
  localparam int LINE_OFF_BITS = $clog2(BUNDLE_BYTES);

  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  typedef logic [31:0]         addr_t;
  typedef logic [GHR_BITS-1:0] ghr_t;

  typedef struct packed {
    addr_t       pc;
    logic [31:0] inst;
    logic        is_branch;
    logic        pred_taken;
    addr_t       pred_target;
    ghr_t        ghr_snapshot;
  } fetch_entry_t;

  typedef fetch_entry_t [FETCH_WIDTH-1:0] fetch_bundle_t;

  // Execute-stage outcome for one branch.
  typedef struct packed {
    logic  valid;
    addr_t pc;
    logic  taken;
    addr_t target;
    ghr_t  ghr_snapshot;
  } bp_resolve_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] inst;
  } cache_lane_t;

endpackage

// File: hw/icache_model.sv
`timescale 1ns/10ps

module icache_model (
  input  logic                                                clock,
  input  logic                                                reset,
  input  logic                                                load_valid_i,
  input  fetch_pkg::addr_t                                    load_addr_i,
  input  logic [31:0]                                         load_data_i,
  input  fetch_pkg::addr_t       [fetch_pkg::FETCH_WIDTH-1:0] read_addr_i,
  output fetch_pkg::cache_lane_t [fetch_pkg::FETCH_WIDTH-1:0] read_lane_o
);

  import fetch_pkg::*;

  logic [31:0]              mem [IMEM_WORDS];
  logic [IMEM_LINES-1:0]    line_valid_q;
  logic [LINE_IDX_BITS-1:0] lane_line [FETCH_WIDTH];
  logic                     miss_found;
  logic [LINE_IDX_BITS-1:0] miss_line;
  logic                     refill_busy_q;
  logic [LINE_IDX_BITS-1:0] refill_line_q;
  logic [MISS_CNT_BITS-1:0] refill_cnt_q;
  logic                     refill_start;
  logic                     refill_done;

  always_ff @(posedge clock) begin
    if (load_valid_i) begin
      mem[load_addr_i[IMEM_IDX_BITS+1:2]] <= load_data_i;
    end
  end

  always_comb begin
    miss_found = 1'b0;
    miss_line  = '0;
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      lane_line[i]         = read_addr_i[i][LINE_IDX_BITS+LINE_OFF_BITS-1:LINE_OFF_BITS];
      read_lane_o[i].valid = line_valid_q[lane_line[i]];
      read_lane_o[i].inst  = mem[read_addr_i[i][IMEM_IDX_BITS+1:2]];
      if (!miss_found && !line_valid_q[lane_line[i]]) begin
        miss_found = 1'b1;
        miss_line  = lane_line[i];
      end
    end
  end

  assign refill_start = miss_found && !refill_busy_q;
  assign refill_done  = refill_busy_q && (refill_cnt_q == MISS_CNT_BITS'(MISS_CYCLES - 1));

  // Start cycle counts as the first stall cycle.
  always_ff @(posedge clock) begin
    if (reset) begin
      line_valid_q  <= '0;
      refill_busy_q <= 1'b0;
      refill_line_q <= '0;
      refill_cnt_q  <= '0;
    end else if (refill_start) begin
      refill_busy_q <= 1'b1;
      refill_line_q <= miss_line;
      refill_cnt_q  <= MISS_CNT_BITS'(1);
    end else if (refill_done) begin
      refill_busy_q               <= 1'b0;
      line_valid_q[refill_line_q] <= 1'b1;
    end else if (refill_busy_q) begin
      refill_cnt_q <= refill_cnt_q + 1'b1;
    end
  end

  // A refill stays on its line until it completes.
  a_single_refill: assert property (
    @(posedge clock) disable iff (reset)
    (refill_busy_q && !refill_done) |=> (refill_busy_q && $stable(refill_line_q))
  );

endmodule

// File: hw/branch_predictor.sv
`timescale 1ns/10ps

module branch_predictor (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   req_valid_i,
  input  fetch_pkg::addr_t       req_pc_i,
  input  logic                   req_used_i,
  input  fetch_pkg::bp_resolve_t resolve_i,
  output logic                   taken_o,
  output fetch_pkg::addr_t       target_o,
  output fetch_pkg::ghr_t        ghr_o
);

  import fetch_pkg::*;

  logic [1:0]               pht_q [PHT_ENTRIES];
  logic [BTB_ENTRIES-1:0]   btb_valid_q;
  logic [BTB_TAG_BITS-1:0]  btb_tag_q [BTB_ENTRIES];
  addr_t                    btb_target_q [BTB_ENTRIES];
  ghr_t                     ghr_q;

  logic [PHT_IDX_BITS-1:0]  pred_idx;
  logic [BTB_IDX_BITS-1:0]  pred_btb_idx;
  logic                     btb_hit;
  logic [PHT_IDX_BITS-1:0]  res_idx;
  logic [BTB_IDX_BITS-1:0]  res_btb_idx;
  logic [1:0]               res_ctr;

  // Gshare index, word pc bits xor history.
  assign pred_idx     = req_pc_i[PHT_IDX_BITS+1:2] ^ PHT_IDX_BITS'(ghr_q);
  assign pred_btb_idx = req_pc_i[BTB_IDX_BITS+1:2];
  assign btb_hit      = btb_valid_q[pred_btb_idx]
                        && (btb_tag_q[pred_btb_idx] == req_pc_i[31:BTB_IDX_BITS+2]);

  assign taken_o  = req_valid_i && pht_q[pred_idx][1] && btb_hit;
  assign target_o = btb_target_q[pred_btb_idx];
  assign ghr_o    = ghr_q;

  assign res_idx     = resolve_i.pc[PHT_IDX_BITS+1:2] ^ PHT_IDX_BITS'(resolve_i.ghr_snapshot);
  assign res_btb_idx = resolve_i.pc[BTB_IDX_BITS+1:2];

  // Saturating two-bit update.
  always_comb begin
    res_ctr = pht_q[res_idx];
    if (resolve_i.taken && res_ctr != 2'b11) begin
      res_ctr = res_ctr + 2'b01;
    end else if (!resolve_i.taken && res_ctr != 2'b00) begin
      res_ctr = res_ctr - 2'b01;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < PHT_ENTRIES; i++) begin
        pht_q[i] <= 2'b01;
      end
      btb_valid_q <= '0;
    end else if (resolve_i.valid) begin
      pht_q[res_idx] <= res_ctr;
      if (resolve_i.taken) begin
        btb_valid_q[res_btb_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (resolve_i.valid && resolve_i.taken) begin
      btb_tag_q[res_btb_idx]    <= resolve_i.pc[31:BTB_IDX_BITS+2];
      btb_target_q[res_btb_idx] <= resolve_i.target;
    end
  end

  // Repair on resolve overrides the speculative shift.
  always_ff @(posedge clock) begin
    if (reset) begin
      ghr_q <= '0;
    end else if (resolve_i.valid) begin
      ghr_q <= {resolve_i.ghr_snapshot[GHR_BITS-2:0], resolve_i.taken};
    end else if (req_used_i) begin
      ghr_q <= {ghr_q[GHR_BITS-2:0], taken_o};
    end
  end

  // Fetch may only consume a prediction it asked for.
  a_used_needs_req: assert property (
    @(posedge clock) disable iff (reset) req_used_i |-> req_valid_i
  );

endmodule

// File: hw/inst_buffer.sv
`timescale 1ns/10ps

module inst_buffer (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     push_i,
  input  fetch_pkg::fetch_bundle_t push_bundle_i,
  output logic                     full_o,
  input  logic                     pop_i,
  output logic                     valid_o,
  output fetch_pkg::fetch_bundle_t bundle_o
);

  import fetch_pkg::*;

  fetch_bundle_t          mem [IB_DEPTH];
  logic [IB_PTR_BITS-1:0] rd_ptr_q;
  logic [IB_PTR_BITS-1:0] wr_ptr_q;
  logic [IB_CNT_BITS-1:0] count_q;
  logic                   do_push;
  logic                   do_pop;

  assign full_o   = (count_q == IB_CNT_BITS'(IB_DEPTH));
  assign valid_o  = (count_q != '0);
  assign bundle_o = mem[rd_ptr_q];

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && valid_o;

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_bundle_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count.
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  a_no_overflow: assert property (
    @(posedge clock) disable iff (reset) push_i |-> !full_o
  );

  a_no_underflow: assert property (
    @(posedge clock) disable iff (reset) pop_i |-> valid_o
  );

endmodule

// File: hw/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage (
  input  logic                                                  clock,
  input  logic                                                  reset,
  input  logic                                                  fetch_enable_i,
  output fetch_pkg::addr_t       [fetch_pkg::FETCH_WIDTH-1:0]   cache_addr_o,
  input  fetch_pkg::cache_lane_t [fetch_pkg::FETCH_WIDTH-1:0]   cache_lane_i,
  input  logic                                                  buffer_full_i,
  output logic                                                  bundle_valid_o,
  output fetch_pkg::fetch_bundle_t                              bundle_o,
  output logic                                                  predict_req_valid_o,
  output fetch_pkg::addr_t                                      predict_req_pc_o,
  output logic                                                  predict_req_used_o,
  input  logic                                                  predict_taken_i,
  input  fetch_pkg::addr_t                                      predict_target_i,
  input  fetch_pkg::ghr_t                                       predict_ghr_i,
  input  logic                                                  redirect_valid_i,
  input  fetch_pkg::addr_t                                      redirect_pc_i
);

  import fetch_pkg::*;

  addr_t                  pc_q;
  addr_t                  pc_next;
  addr_t [FETCH_WIDTH-1:0] lane_pc;
  logic  [FETCH_WIDTH-1:0] lane_branch;
  logic                   lanes_ready;
  logic                   found_branch;
  logic  [LANE_BITS-1:0]  branch_idx;

  function automatic logic is_cond_branch(input cache_lane_t lane);
    return lane.valid && (lane.inst[6:0] == OPC_BRANCH);
  endfunction

  // Lane addresses are consecutive words.
  always_comb begin
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      lane_pc[i] = pc_q + addr_t'(4 * i);
    end
  end

  assign cache_addr_o = lane_pc;

  always_comb begin
    lanes_ready = 1'b1;
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      lane_branch[i] = is_cond_branch(cache_lane_i[i]);
      if (!cache_lane_i[i].valid) begin
        lanes_ready = 1'b0;
      end
    end
  end

  // First branch wins, later lanes are not predicted.
  always_comb begin
    found_branch = 1'b0;
    branch_idx   = '0;
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      if (!found_branch && lane_branch[i]) begin
        found_branch = 1'b1;
        branch_idx   = LANE_BITS'(i);
      end
    end
  end

  assign bundle_valid_o = fetch_enable_i && lanes_ready && !buffer_full_i && !redirect_valid_i;

  assign predict_req_valid_o = fetch_enable_i && found_branch;
  assign predict_req_pc_o    = lane_pc[branch_idx];
  assign predict_req_used_o  = bundle_valid_o && found_branch;

  always_comb begin
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      bundle_o[i].pc           = lane_pc[i];
      bundle_o[i].inst         = cache_lane_i[i].inst;
      bundle_o[i].is_branch    = 1'b0;
      bundle_o[i].pred_taken   = 1'b0;
      bundle_o[i].pred_target  = '0;
      bundle_o[i].ghr_snapshot = '0;
    end
    if (found_branch) begin
      bundle_o[branch_idx].is_branch    = 1'b1;
      bundle_o[branch_idx].pred_taken   = predict_taken_i;
      bundle_o[branch_idx].pred_target  = predict_target_i;
      bundle_o[branch_idx].ghr_snapshot = predict_ghr_i;
    end
  end

  // Redirect, then predicted target, then next bundle.
  always_comb begin
    pc_next = pc_q;
    if (redirect_valid_i) begin
      pc_next = redirect_pc_i;
    end else if (bundle_valid_o) begin
      if (found_branch && predict_taken_i) begin
        pc_next = predict_target_i;
      end else begin
        pc_next = pc_q + addr_t'(BUNDLE_BYTES);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_next;
    end
  end

  // A taken prediction only answers a request from this stage.
  a_taken_needs_req: assert property (
    @(posedge clock) disable iff (reset) predict_taken_i |-> predict_req_valid_o
  );

endmodule

// File: hw/fetch_top.sv
`timescale 1ns/10ps

module fetch_top (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     fetch_enable_i,
  input  logic                     load_valid_i,
  input  fetch_pkg::addr_t         load_addr_i,
  input  logic [31:0]              load_data_i,
  input  logic                     redirect_valid_i,
  input  fetch_pkg::addr_t         redirect_pc_i,
  input  fetch_pkg::bp_resolve_t   resolve_i,
  input  logic                     decode_ready_i,
  output logic                     decode_valid_o,
  output fetch_pkg::fetch_bundle_t decode_bundle_o
);

  import fetch_pkg::*;

  addr_t       [FETCH_WIDTH-1:0] cache_addr;
  cache_lane_t [FETCH_WIDTH-1:0] cache_lane;
  logic                          buffer_full;
  logic                          bundle_valid;
  fetch_bundle_t                 bundle;
  logic                          req_valid;
  addr_t                         req_pc;
  logic                          req_used;
  logic                          pred_taken;
  addr_t                         pred_target;
  ghr_t                          pred_ghr;

  fetch_stage u_fetch_stage (
    .clock               (clock),
    .reset               (reset),
    .fetch_enable_i      (fetch_enable_i),
    .cache_addr_o        (cache_addr),
    .cache_lane_i        (cache_lane),
    .buffer_full_i       (buffer_full),
    .bundle_valid_o      (bundle_valid),
    .bundle_o            (bundle),
    .predict_req_valid_o (req_valid),
    .predict_req_pc_o    (req_pc),
    .predict_req_used_o  (req_used),
    .predict_taken_i     (pred_taken),
    .predict_target_i    (pred_target),
    .predict_ghr_i       (pred_ghr),
    .redirect_valid_i    (redirect_valid_i),
    .redirect_pc_i       (redirect_pc_i)
  );

  icache_model u_icache_model (
    .clock        (clock),
    .reset        (reset),
    .load_valid_i (load_valid_i),
    .load_addr_i  (load_addr_i),
    .load_data_i  (load_data_i),
    .read_addr_i  (cache_addr),
    .read_lane_o  (cache_lane)
  );

  branch_predictor u_branch_predictor (
    .clock       (clock),
    .reset       (reset),
    .req_valid_i (req_valid),
    .req_pc_i    (req_pc),
    .req_used_i  (req_used),
    .resolve_i   (resolve_i),
    .taken_o     (pred_taken),
    .target_o    (pred_target),
    .ghr_o       (pred_ghr)
  );

  // Pop only a valid head.
  inst_buffer u_inst_buffer (
    .clock         (clock),
    .reset         (reset),
    .push_i        (bundle_valid),
    .push_bundle_i (bundle),
    .full_o        (buffer_full),
    .pop_i         (decode_ready_i && decode_valid_o),
    .valid_o       (decode_valid_o),
    .bundle_o      (decode_bundle_o)
  );

endmodule

// File: tests/tb_fetch_table.svh
`ifndef TB_FETCH_TABLE_SVH
`define TB_FETCH_TABLE_SVH

// Branch at 0x14 and the values used to train it.
localparam int          BRANCH_WORD  = 5;
localparam logic [31:0] BRANCH_INST  = 32'h0000_0063;
localparam addr_t       TRAIN_PC     = 32'h0000_0014;
localparam addr_t       TRAIN_TARGET = 32'h0000_0040;
localparam ghr_t        TRAIN_GHR    = 4'hF;

typedef struct {
  string       name;
  bit          wait_full;
  bit          fetch_en;
  bit          redirect;
  addr_t       redirect_pc;
  bit          resolve;
  bit          check;
  addr_t       exp_pc;
  logic [1:0]  exp_branch;
  logic [1:0]  exp_taken;
  bit          backpressure;
  bit          idle;
} test_row_t;

localparam int NUM_ROWS = 31;

// name, wait_full, fetch_en, redirect, redirect_pc, resolve, check,
// exp_pc, exp_branch {lane1,lane0}, exp_taken {lane1,lane0}, backpressure, idle
test_row_t rows [NUM_ROWS] = '{
  '{"seq_0",          0, 1, 0, 32'h0,  0, 1, 32'h00, 2'b00, 2'b00, 0, 0},
  '{"seq_8",          0, 1, 0, 32'h0,  0, 1, 32'h08, 2'b00, 2'b00, 0, 0},
  '{"cold_branch",    0, 1, 0, 32'h0,  0, 1, 32'h10, 2'b10, 2'b00, 0, 0},
  '{"cold_next",      0, 1, 0, 32'h0,  0, 1, 32'h18, 2'b00, 2'b00, 0, 0},
  '{"seq_20",         0, 1, 0, 32'h0,  0, 1, 32'h20, 2'b00, 2'b00, 0, 0},
  '{"redir_old0",     1, 1, 1, 32'h80, 0, 1, 32'h28, 2'b00, 2'b00, 0, 0},
  '{"redir_old1",     0, 1, 0, 32'h0,  0, 1, 32'h30, 2'b00, 2'b00, 0, 0},
  '{"redir_old2",     0, 1, 0, 32'h0,  0, 1, 32'h38, 2'b00, 2'b00, 0, 0},
  '{"redir_old3",     0, 1, 0, 32'h0,  0, 1, 32'h40, 2'b00, 2'b00, 0, 0},
  '{"redir_new0",     0, 1, 0, 32'h0,  0, 1, 32'h80, 2'b00, 2'b00, 0, 0},
  '{"redir_new1",     0, 1, 0, 32'h0,  0, 1, 32'h88, 2'b00, 2'b00, 0, 0},
  '{"bp_0",           0, 1, 0, 32'h0,  0, 1, 32'h90, 2'b00, 2'b00, 1, 0},
  '{"bp_1",           0, 1, 0, 32'h0,  0, 1, 32'h98, 2'b00, 2'b00, 1, 0},
  '{"bp_2",           0, 1, 0, 32'h0,  0, 1, 32'hA0, 2'b00, 2'b00, 1, 0},
  '{"bp_3",           0, 1, 0, 32'h0,  0, 1, 32'hA8, 2'b00, 2'b00, 1, 0},
  '{"bp_4",           0, 1, 0, 32'h0,  0, 1, 32'hB0, 2'b00, 2'b00, 1, 0},
  '{"off_drain0",     1, 0, 0, 32'h0,  0, 1, 32'hB8, 2'b00, 2'b00, 0, 0},
  '{"off_drain1",     0, 0, 0, 32'h0,  0, 1, 32'hC0, 2'b00, 2'b00, 0, 0},
  '{"off_drain2",     0, 0, 0, 32'h0,  0, 1, 32'hC8, 2'b00, 2'b00, 0, 0},
  '{"off_drain3",     0, 0, 0, 32'h0,  0, 1, 32'hD0, 2'b00, 2'b00, 0, 0},
  '{"off_idle",       0, 0, 0, 32'h0,  0, 0, 32'h00, 2'b00, 2'b00, 0, 1},
  '{"train_res0",     0, 0, 0, 32'h0,  1, 0, 32'h00, 2'b00, 2'b00, 0, 0},
  '{"train_res1",     0, 0, 0, 32'h0,  1, 0, 32'h00, 2'b00, 2'b00, 0, 0},
  '{"resume",         0, 1, 0, 32'h0,  0, 1, 32'hD8, 2'b00, 2'b00, 0, 0},
  '{"train_old0",     1, 1, 1, 32'h10, 0, 1, 32'hE0, 2'b00, 2'b00, 0, 0},
  '{"train_old1",     0, 1, 0, 32'h0,  0, 1, 32'hE8, 2'b00, 2'b00, 0, 0},
  '{"train_old2",     0, 1, 0, 32'h0,  0, 1, 32'hF0, 2'b00, 2'b00, 0, 0},
  '{"train_old3",     0, 1, 0, 32'h0,  0, 1, 32'hF8, 2'b00, 2'b00, 0, 0},
  '{"trained_branch", 0, 1, 0, 32'h0,  0, 1, 32'h10, 2'b10, 2'b10, 0, 0},
  '{"trained_target", 0, 1, 0, 32'h0,  0, 1, 32'h40, 2'b00, 2'b00, 0, 0},
  '{"target_next",    0, 1, 0, 32'h0,  0, 1, 32'h48, 2'b00, 2'b00, 0, 0}
};

// Addi with the word index as immediate, one branch at BRANCH_WORD.
function automatic logic [31:0] program_word(input int idx);
  if (idx == BRANCH_WORD) begin
    return BRANCH_INST;
  end
  return {12'(idx), 5'd0, 3'b000, 5'd0, 7'b0010011};
endfunction

`endif

// File: tests/tb_fetch_top.sv
`timescale 1ns/10ps

module tb_fetch_top;

  import fetch_pkg::*;

  `include "tb_fetch_table.svh"

  localparam int TIMEOUT_CYCLES = 200;
  localparam int IDLE_CYCLES    = 8;

  logic          clock;
  logic          reset;
  logic          fetch_enable_i;
  logic          load_valid_i;
  addr_t         load_addr_i;
  logic [31:0]   load_data_i;
  logic          redirect_valid_i;
  addr_t         redirect_pc_i;
  bp_resolve_t   resolve_i;
  logic          decode_ready_i;
  logic          decode_valid_o;
  fetch_bundle_t decode_bundle_o;

  int errors;
  int checks;
  int seed_val;
  bit timed_out;

  fetch_top u_fetch_top (
    .clock            (clock),
    .reset            (reset),
    .fetch_enable_i   (fetch_enable_i),
    .load_valid_i     (load_valid_i),
    .load_addr_i      (load_addr_i),
    .load_data_i      (load_data_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .resolve_i        (resolve_i),
    .decode_ready_i   (decode_ready_i),
    .decode_valid_o   (decode_valid_o),
    .decode_bundle_o  (decode_bundle_o)
  );

  initial begin
    clock = 1'b0;
  end

  always #4 clock = ~clock;

  task automatic compare(input string name, input string what,
                         input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", name, what, expected, actual);
    end
  endtask

  task automatic finish_run();
    $display("Result: %0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  task automatic step();
    @(posedge clock);
    #1;
  endtask

  task automatic report_timeout(input string what);
    errors++;
    timed_out = 1'b1;
    $display("Timeout while waiting for %s", what);
  endtask

  task automatic wait_decode_valid(input string name);
    int cycles;
    cycles = 0;
    while (!decode_valid_o && !timed_out) begin
      step();
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        report_timeout({"decode valid in row ", name});
      end
    end
  endtask

  // Peeks at the buffer's full level to start a row from a known fill.
  task automatic wait_buffer_full(input string name);
    int cycles;
    cycles = 0;
    while (!u_fetch_top.buffer_full && !timed_out) begin
      step();
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        report_timeout({"a full buffer in row ", name});
      end
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < IMEM_WORDS; i++) begin
      load_valid_i = 1'b1;
      load_addr_i  = addr_t'(4 * i);
      load_data_i  = program_word(i);
      step();
    end
    load_valid_i = 1'b0;
  endtask

  task automatic apply_row(input test_row_t row);
    int delay;
    addr_t lane_pc;
    logic [1:0] branch_bits;
    logic [1:0] taken_bits;
    if (row.wait_full) begin
      wait_buffer_full(row.name);
      if (timed_out) begin
        return;
      end
    end
    fetch_enable_i   = row.fetch_en;
    redirect_valid_i = row.redirect;
    redirect_pc_i    = row.redirect_pc;
    resolve_i        = '{valid: row.resolve, pc: TRAIN_PC, taken: 1'b1,
                         target: TRAIN_TARGET, ghr_snapshot: TRAIN_GHR};
    if (row.redirect || row.resolve) begin
      step();
      redirect_valid_i = 1'b0;
      resolve_i.valid  = 1'b0;
    end
    if (row.idle) begin
      repeat (IDLE_CYCLES) begin
        step();
        compare(row.name, "decode_valid", 32'd0, 32'(decode_valid_o));
      end
    end
    if (row.check) begin
      wait_decode_valid(row.name);
      if (timed_out) begin
        return;
      end
      if (row.backpressure) begin
        delay = int'($urandom % 8);
        repeat (delay) step();
      end
      branch_bits = {decode_bundle_o[1].is_branch, decode_bundle_o[0].is_branch};
      taken_bits  = {decode_bundle_o[1].pred_taken, decode_bundle_o[0].pred_taken};
      // Lanes hold consecutive program words.
      for (int i = 0; i < FETCH_WIDTH; i++) begin
        lane_pc = row.exp_pc + addr_t'(4 * i);
        compare(row.name, "pc", lane_pc, decode_bundle_o[i].pc);
        compare(row.name, "inst", program_word(int'(lane_pc >> 2)), decode_bundle_o[i].inst);
      end
      compare(row.name, "is_branch", 32'(row.exp_branch), 32'(branch_bits));
      compare(row.name, "pred_taken", 32'(row.exp_taken), 32'(taken_bits));
      decode_ready_i = 1'b1;
      step();
      decode_ready_i = 1'b0;
    end
  endtask

  initial begin
    errors    = 0;
    checks    = 0;
    timed_out = 1'b0;
    seed_val  = $urandom(32'h4ca262b8);
    reset            = 1'b1;
    fetch_enable_i   = 1'b0;
    load_valid_i     = 1'b0;
    load_addr_i      = '0;
    load_data_i      = '0;
    redirect_valid_i = 1'b0;
    redirect_pc_i    = '0;
    resolve_i        = '0;
    decode_ready_i   = 1'b0;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    load_program();
    for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
      apply_row(rows[i]);
    end
    finish_run();
  end

endmodule

// File: sim.f
+incdir+tests
hw/fetch_pkg.sv
hw/icache_model.sv
hw/branch_predictor.sv
hw/inst_buffer.sv
hw/fetch_stage.sv
hw/fetch_top.sv
tests/tb_fetch_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_fetch_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
